/* flist.f */
+incdir+tb
source/lc3b_isa_pkg.sv
source/lc3b_branch_pkg.sv
source/branch_predictor.sv
source/branch_waterfall_queue.sv
source/branch_controller.sv
source/branch_unit_top.sv
tb/branch_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module branch_unit_tb -o branch_unit_sim

output=$(./obj_dir/branch_unit_sim)
echo "$output"

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
else
    exit 1
fi

/* source/branch_controller.sv */
module branch_controller (
    input  logic clk,
    input  logic rst_n,

    input  logic                                fetch_valid,
    input  logic [lc3b_isa_pkg::word_width-1:0] fetch_pc,
    input  logic [lc3b_isa_pkg::word_width-1:0] fetch_ir,

    input  logic                                ex_mem_valid,
    input  lc3b_isa_pkg::lc3b_opcode            ex_mem_opcode,
    input  logic                                ex_mem_br_en,
    input  logic [lc3b_isa_pkg::word_width-1:0] ex_mem_target,

    input  logic                                mem_wb_valid,
    input  lc3b_isa_pkg::lc3b_opcode            mem_wb_opcode,
    input  logic [lc3b_isa_pkg::word_width-1:0] mem_wb_trap_vector,

    input  logic                                predict_taken,
    input  logic                                head_prediction,
    input  logic [lc3b_isa_pkg::word_width-1:0] head_recovery_address,
    input  logic                                empty,

    output logic                                push,
    output logic                                push_prediction,
    output logic [lc3b_isa_pkg::word_width-1:0] push_recovery_address,
    output logic                                pop,
    output logic                                clear,
    output logic                                train,
    output logic                                train_taken,

    output logic [lc3b_isa_pkg::word_width-1:0] pc_out,
    output logic [3:0]                          flush,
    output logic                                prediction_correct,
    output logic                                prediction_incorrect
);

    localparam int offset_pad = lc3b_isa_pkg::word_width - lc3b_isa_pkg::br_offset_width - 1;

    lc3b_isa_pkg::lc3b_opcode            fetch_opcode;
    logic                                fetch_br;
    logic                                ex_br;
    logic [lc3b_isa_pkg::word_width-1:0] fetch_pc_plus2;
    logic [lc3b_isa_pkg::word_width-1:0] br_offset;
    logic [lc3b_isa_pkg::word_width-1:0] fetch_branch_target;
    lc3b_branch_pkg::lc3b_pc_sel         pc_sel;

    assign fetch_opcode = lc3b_isa_pkg::lc3b_opcode'(
        fetch_ir[lc3b_isa_pkg::opcode_msb:lc3b_isa_pkg::opcode_lsb]);
    assign fetch_br = fetch_valid && fetch_opcode == lc3b_isa_pkg::op_br;
    assign ex_br    = ex_mem_valid && ex_mem_opcode == lc3b_isa_pkg::op_br;

    // word offset, sign extended and scaled to bytes.
    assign br_offset = {{offset_pad{fetch_ir[lc3b_isa_pkg::br_offset_width-1]}},
                        fetch_ir[lc3b_isa_pkg::br_offset_width-1:0], 1'b0};

    assign fetch_pc_plus2      = fetch_pc + 16'd2;
    assign fetch_branch_target = fetch_pc_plus2 + br_offset;

    // the queue keeps the path not taken at fetch.
    assign push_prediction       = predict_taken;
    assign push_recovery_address = predict_taken ? fetch_pc_plus2 : fetch_branch_target;

    assign pop         = ex_br;
    assign train       = ex_br;
    assign train_taken = ex_mem_br_en;

    // later checks override earlier ones, so the order below sets priority.
    always_comb begin
        pc_sel               = lc3b_branch_pkg::pc_plus2;
        flush                = '0;
        prediction_correct   = 1'b0;
        prediction_incorrect = 1'b0;

        if (fetch_br && predict_taken) begin
            pc_sel = lc3b_branch_pkg::branch_target;
        end

        if (ex_br) begin
            if (head_prediction == ex_mem_br_en) begin
                prediction_correct = 1'b1;
            end else begin
                prediction_incorrect = 1'b1;
                pc_sel = lc3b_branch_pkg::mispredict_address;
                flush[lc3b_branch_pkg::flush_if_id]  = 1'b1;
                flush[lc3b_branch_pkg::flush_id_ex]  = 1'b1;
                flush[lc3b_branch_pkg::flush_ex_mem] = 1'b1;
            end
        end

        if (ex_mem_valid && (ex_mem_opcode == lc3b_isa_pkg::op_jmp ||
                             ex_mem_opcode == lc3b_isa_pkg::op_jsr)) begin
            pc_sel = lc3b_branch_pkg::redirect_target;
            flush[lc3b_branch_pkg::flush_if_id]  = 1'b1;
            flush[lc3b_branch_pkg::flush_id_ex]  = 1'b1;
            flush[lc3b_branch_pkg::flush_ex_mem] = 1'b1;
        end

        // trap squashes younger work now and redirects from writeback.
        if (ex_mem_valid && ex_mem_opcode == lc3b_isa_pkg::op_trap) begin
            flush[lc3b_branch_pkg::flush_if_id]  = 1'b1;
            flush[lc3b_branch_pkg::flush_id_ex]  = 1'b1;
            flush[lc3b_branch_pkg::flush_ex_mem] = 1'b1;
        end

        if (mem_wb_valid && mem_wb_opcode == lc3b_isa_pkg::op_trap) begin
            pc_sel = lc3b_branch_pkg::trap_vector;
            flush[lc3b_branch_pkg::flush_if_id]  = 1'b1;
            flush[lc3b_branch_pkg::flush_id_ex]  = 1'b1;
            flush[lc3b_branch_pkg::flush_ex_mem] = 1'b1;
            flush[lc3b_branch_pkg::flush_mem_wb] = 1'b1;
        end
    end

    // a BR fetched under a flush is squashed, so it is never queued.
    assign push  = fetch_br && (flush == 4'b0000);
    assign clear = |flush;

    always_comb begin
        case (pc_sel)
            lc3b_branch_pkg::branch_target:      pc_out = fetch_branch_target;
            lc3b_branch_pkg::redirect_target:    pc_out = ex_mem_target;
            lc3b_branch_pkg::mispredict_address: pc_out = head_recovery_address;
            lc3b_branch_pkg::trap_vector:        pc_out = mem_wb_trap_vector;
            default:                             pc_out = fetch_pc_plus2;
        endcase
    end

    a_one_verdict : assert property (@(posedge clk) disable iff (!rst_n)
        !(prediction_correct && prediction_incorrect))
        else $error("both prediction verdicts set");

    // each resolving BR must have been queued at fetch.
    a_br_has_entry : assert property (@(posedge clk) disable iff (!rst_n)
        ex_br |-> !empty)
        else $error("BR at execute/memory with no queued prediction");

endmodule : branch_controller

/* source/branch_predictor.sv */
module branch_predictor (
    input  logic clk,
    input  logic rst_n,

    input  logic train,
    input  logic train_taken,

    output logic predict_taken
);

    logic [1:0] counter;

    // one global counter shared by every BR.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter <= lc3b_branch_pkg::counter_reset;
        end else if (train) begin
            if (train_taken && counter != 2'b11) begin
                counter <= counter + 2'd1;
            end else if (!train_taken && counter != 2'b00) begin
                counter <= counter - 2'd1;
            end
        end
    end

    // upper bit set means strongly or weakly taken.
    assign predict_taken = counter[1];

endmodule : branch_predictor

/* source/branch_unit_top.sv */
module branch_unit_top (
    input  logic clk,
    input  logic rst_n,

    input  logic                                fetch_valid,
    input  logic [lc3b_isa_pkg::word_width-1:0] fetch_pc,
    input  logic [lc3b_isa_pkg::word_width-1:0] fetch_ir,

    input  logic                                ex_mem_valid,
    input  lc3b_isa_pkg::lc3b_opcode            ex_mem_opcode,
    input  logic                                ex_mem_br_en,
    input  logic [lc3b_isa_pkg::word_width-1:0] ex_mem_target,

    input  logic                                mem_wb_valid,
    input  lc3b_isa_pkg::lc3b_opcode            mem_wb_opcode,
    input  logic [lc3b_isa_pkg::word_width-1:0] mem_wb_trap_vector,

    output logic [lc3b_isa_pkg::word_width-1:0] pc_out,
    output logic [3:0]                          flush,
    output logic                                prediction_correct,
    output logic                                prediction_incorrect
);

    logic                                predict_taken;
    logic                                train;
    logic                                train_taken;
    logic                                push;
    logic                                push_prediction;
    logic [lc3b_isa_pkg::word_width-1:0] push_recovery_address;
    logic                                pop;
    logic                                clear;
    logic                                head_prediction;
    logic [lc3b_isa_pkg::word_width-1:0] head_recovery_address;
    logic                                empty;

    branch_predictor i_branch_predictor (
        .clk,
        .rst_n,
        .train,
        .train_taken,
        .predict_taken
    );

    branch_waterfall_queue i_branch_waterfall_queue (
        .clk,
        .rst_n,
        .push,
        .push_prediction,
        .push_recovery_address,
        .pop,
        .clear,
        .head_prediction,
        .head_recovery_address,
        .empty
    );

    branch_controller i_branch_controller (
        .clk,
        .rst_n,
        .fetch_valid,
        .fetch_pc,
        .fetch_ir,
        .ex_mem_valid,
        .ex_mem_opcode,
        .ex_mem_br_en,
        .ex_mem_target,
        .mem_wb_valid,
        .mem_wb_opcode,
        .mem_wb_trap_vector,
        .predict_taken,
        .head_prediction,
        .head_recovery_address,
        .empty,
        .push,
        .push_prediction,
        .push_recovery_address,
        .pop,
        .clear,
        .train,
        .train_taken,
        .pc_out,
        .flush,
        .prediction_correct,
        .prediction_incorrect
    );

endmodule : branch_unit_top

/* source/branch_waterfall_queue.sv */
module branch_waterfall_queue (
    input  logic clk,
    input  logic rst_n,

    input  logic                                push,
    input  logic                                push_prediction,
    input  logic [lc3b_isa_pkg::word_width-1:0] push_recovery_address,
    input  logic                                pop,
    input  logic                                clear,

    output logic                                head_prediction,
    output logic [lc3b_isa_pkg::word_width-1:0] head_recovery_address,
    output logic                                empty
);

    logic                                prediction_mem [lc3b_branch_pkg::queue_depth];
    logic [lc3b_isa_pkg::word_width-1:0] address_mem [lc3b_branch_pkg::queue_depth];

    logic [lc3b_branch_pkg::queue_ptr_width-1:0]   rd_ptr;
    logic [lc3b_branch_pkg::queue_ptr_width-1:0]   wr_ptr;
    logic [lc3b_branch_pkg::queue_count_width-1:0] count;
    logic                                          full;

    function automatic logic [lc3b_branch_pkg::queue_ptr_width-1:0] next_ptr(
        input logic [lc3b_branch_pkg::queue_ptr_width-1:0] ptr
    );
        if (int'(ptr) == lc3b_branch_pkg::queue_depth - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            // a flush drops every outstanding prediction, including this cycle's.
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !clear) begin
            prediction_mem[wr_ptr] <= push_prediction;
            address_mem[wr_ptr]    <= push_recovery_address;
        end
    end

    // show-ahead head entry.
    assign head_prediction       = prediction_mem[rd_ptr];
    assign head_recovery_address = address_mem[rd_ptr];

    assign empty = (count == '0);
    assign full  = (int'(count) == lc3b_branch_pkg::queue_depth);

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full && !pop && !clear))
        else $error("branch queue push while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty))
        else $error("branch queue pop while empty");

endmodule : branch_waterfall_queue

/* source/lc3b_branch_pkg.sv */
package lc3b_branch_pkg;

    // sources for the next fetch address.
    typedef enum logic [2:0] {
        pc_plus2,
        branch_target,
        redirect_target,
        mispredict_address,
        trap_vector
    } lc3b_pc_sel;

    // bit positions in the pipeline barrier flush mask.
    localparam int flush_if_id  = 0;
    localparam int flush_id_ex  = 1;
    localparam int flush_ex_mem = 2;
    localparam int flush_mem_wb = 3;

    // covers every BR that can sit between fetch and execute/memory.
    localparam int queue_depth       = 4;
    localparam int queue_ptr_width   = $clog2(queue_depth);
    localparam int queue_count_width = $clog2(queue_depth + 1);

    // weakly not taken.
    localparam logic [1:0] counter_reset = 2'b01;

endpackage : lc3b_branch_pkg

/* source/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    localparam int word_width = 16;

    // opcode field of an instruction word.
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;

    // BR carries a nine-bit word offset in its low bits.
    localparam int br_offset_width = 9;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

endpackage : lc3b_isa_pkg

/* tb/branch_unit_model.svh */
`ifndef BRANCH_UNIT_MODEL_SVH
`define BRANCH_UNIT_MODEL_SVH

// reference copy of the global counter and the outstanding predictions.
logic [1:0]                          ref_counter = lc3b_branch_pkg::counter_reset;
logic                                pending_pred [$];
logic [lc3b_isa_pkg::word_width-1:0] pending_addr [$];

function automatic logic [lc3b_isa_pkg::word_width-1:0] expected_target(
    input logic [lc3b_isa_pkg::word_width-1:0] pc,
    input logic [lc3b_isa_pkg::word_width-1:0] ir
);
    int offset;
    offset = ir[8] ? int'(ir[8:0]) - 512 : int'(ir[8:0]);
    return pc + 16'(2 + 2 * offset);
endfunction

function automatic logic fetch_is_br();
    return fetch_valid &&
        fetch_ir[lc3b_isa_pkg::opcode_msb:lc3b_isa_pkg::opcode_lsb] == lc3b_isa_pkg::op_br;
endfunction

function automatic void expected_outputs(
    output logic [lc3b_isa_pkg::word_width-1:0] pc,
    output logic [3:0]                          fl,
    output logic                                correct,
    output logic                                incorrect
);
    logic ex_is_br;
    logic head;
    ex_is_br  = ex_mem_valid && ex_mem_opcode == lc3b_isa_pkg::op_br;
    head      = (pending_pred.size() > 0) ? pending_pred[0] : 1'b0;
    correct   = ex_is_br && head == ex_mem_br_en;
    incorrect = ex_is_br && head != ex_mem_br_en;
    fl        = 4'b0000;
    // highest priority first.
    if (mem_wb_valid && mem_wb_opcode == lc3b_isa_pkg::op_trap) begin
        pc = mem_wb_trap_vector;
        fl = 4'b1111;
    end else if (ex_mem_valid && (ex_mem_opcode == lc3b_isa_pkg::op_jmp ||
                                  ex_mem_opcode == lc3b_isa_pkg::op_jsr)) begin
        pc = ex_mem_target;
        fl = 4'b0111;
    end else if (incorrect) begin
        pc = pending_addr[0];
        fl = 4'b0111;
    end else begin
        if (ex_mem_valid && ex_mem_opcode == lc3b_isa_pkg::op_trap) begin
            fl = 4'b0111;
        end
        if (fetch_is_br() && ref_counter[1]) begin
            pc = expected_target(fetch_pc, fetch_ir);
        end else begin
            pc = fetch_pc + 16'd2;
        end
    end
endfunction

// applies the effect of one rising edge.
function automatic void advance_model(input logic [3:0] fl);
    logic ex_is_br;
    logic taken;
    ex_is_br = ex_mem_valid && ex_mem_opcode == lc3b_isa_pkg::op_br;
    taken    = ref_counter[1];
    if (fl != 4'b0000) begin
        pending_pred.delete();
        pending_addr.delete();
    end else begin
        if (ex_is_br && pending_pred.size() > 0) begin
            void'(pending_pred.pop_front());
            void'(pending_addr.pop_front());
        end
        if (fetch_is_br()) begin
            pending_pred.push_back(taken);
            pending_addr.push_back(taken ? fetch_pc + 16'd2 : expected_target(fetch_pc, fetch_ir));
        end
    end
    if (ex_is_br) begin
        if (ex_mem_br_en && ref_counter != 2'b11) begin
            ref_counter = ref_counter + 2'd1;
        end else if (!ex_mem_br_en && ref_counter != 2'b00) begin
            ref_counter = ref_counter - 2'd1;
        end
    end
endfunction

`endif

/* tb/branch_unit_tb.sv */
module branch_unit_tb;

    localparam int half_period   = 50;
    localparam int sample_delay  = 25;
    localparam int reset_cycles  = 2;
    localparam int idle_cycles   = 4;
    localparam int random_cycles = 24;
    // reset, idle, three BR phases, random, jmp and jsr, trap, one closing cycle per test.
    localparam int test_cycles   = reset_cycles + idle_cycles + 18 + random_cycles + 8 + 2 + 5;
    localparam int watchdog_time = (test_cycles + 20) * 2 * half_period;

    logic                                clk = 1'b0;
    logic                                rst_n;
    logic                                fetch_valid;
    logic [lc3b_isa_pkg::word_width-1:0] fetch_pc;
    logic [lc3b_isa_pkg::word_width-1:0] fetch_ir;
    logic                                ex_mem_valid;
    lc3b_isa_pkg::lc3b_opcode            ex_mem_opcode;
    logic                                ex_mem_br_en;
    logic [lc3b_isa_pkg::word_width-1:0] ex_mem_target;
    logic                                mem_wb_valid;
    lc3b_isa_pkg::lc3b_opcode            mem_wb_opcode;
    logic [lc3b_isa_pkg::word_width-1:0] mem_wb_trap_vector;
    logic [lc3b_isa_pkg::word_width-1:0] pc_out;
    logic [3:0]                          flush;
    logic                                prediction_correct;
    logic                                prediction_incorrect;

    integer seed = 32'h7e2c;
    int     err_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    `include "branch_unit_model.svh"

    branch_unit_top i_branch_unit_top (.*);

    always #(half_period) clk = ~clk;

    function automatic logic [lc3b_isa_pkg::word_width-1:0] random_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic [lc3b_isa_pkg::word_width-1:0] random_br_ir();
        logic [15:0] w;
        w = random_word();
        return {lc3b_isa_pkg::op_br, w[11:0]};
    endfunction

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        assert (expected === actual) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        fetch_valid  = 1'b0;
        ex_mem_valid = 1'b0;
        mem_wb_valid = 1'b0;
    endtask

    task automatic drive_fetch(input logic [15:0] pc, input logic [15:0] ir);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_ir    = ir;
    endtask

    task automatic drive_execute(input lc3b_isa_pkg::lc3b_opcode op, input logic br_en,
                                 input logic [15:0] target);
        ex_mem_valid  = 1'b1;
        ex_mem_opcode = op;
        ex_mem_br_en  = br_en;
        ex_mem_target = target;
    endtask

    task automatic drive_writeback(input lc3b_isa_pkg::lc3b_opcode op, input logic [15:0] vector);
        mem_wb_valid       = 1'b1;
        mem_wb_opcode      = op;
        mem_wb_trap_vector = vector;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        next_cycle();
        if (err_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errors_before);
        end
    endtask

    // outputs are sampled well before the rising edge, then the model steps.
    initial begin
        logic [15:0] exp_pc;
        logic [3:0]  exp_flush;
        logic        exp_correct;
        logic        exp_incorrect;
        forever begin
            @(negedge clk);
            #(sample_delay);
            if (rst_n) begin
                expected_outputs(exp_pc, exp_flush, exp_correct, exp_incorrect);
                compare_value("pc_out", exp_pc, pc_out);
                compare_value("flush", 16'(exp_flush), 16'(flush));
                compare_value("prediction_correct", 16'(exp_correct), 16'(prediction_correct));
                compare_value("prediction_incorrect", 16'(exp_incorrect),
                              16'(prediction_incorrect));
                advance_model(exp_flush);
            end
        end
    end

    initial begin
        #(watchdog_time);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int                                  start;
        logic [lc3b_isa_pkg::word_width-1:0] br_pc [3];
        logic [lc3b_isa_pkg::word_width-1:0] br_ir [3];
        logic [31:0]                         r;
        rst_n              = 1'b0;
        fetch_valid        = 1'b0;
        fetch_pc           = '0;
        fetch_ir           = '0;
        ex_mem_valid       = 1'b0;
        ex_mem_opcode      = lc3b_isa_pkg::op_add;
        ex_mem_br_en       = 1'b0;
        ex_mem_target      = '0;
        mem_wb_valid       = 1'b0;
        mem_wb_opcode      = lc3b_isa_pkg::op_add;
        mem_wb_trap_vector = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        start = err_count;
        repeat (idle_cycles) begin
            next_cycle();
            fetch_pc = random_word() & 16'hfffe;
        end
        finish_test("after reset", start);

        start = err_count;
        for (int i = 0; i < 3; i++) begin
            br_pc[i] = random_word() & 16'hfffe;
            br_ir[i] = random_br_ir();
        end
        // weakly not taken, resolved not taken.
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            drive_fetch(br_pc[i], br_ir[i]);
            next_cycle();
            drive_execute(lc3b_isa_pkg::op_br, 1'b0, '0);
        end
        // train the counter up to strongly taken.
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            drive_fetch(random_word() & 16'hfffe, random_br_ir());
            next_cycle();
            drive_execute(lc3b_isa_pkg::op_br, 1'b1, '0);
        end
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            drive_fetch(br_pc[i], br_ir[i]);
            next_cycle();
            drive_execute(lc3b_isa_pkg::op_br, 1'b1, '0);
        end
        finish_test("br at fetch", start);

        start = err_count;
        repeat (random_cycles) begin
            next_cycle();
            r = $random(seed);
            if (pending_pred.size() > 0 && r[0]) begin
                drive_execute(lc3b_isa_pkg::op_br, r[1], '0);
            end
            if (pending_pred.size() < 3 && r[2]) begin
                drive_fetch(random_word() & 16'hfffe, random_br_ir());
            end
        end
        finish_test("br resolution", start);

        start = err_count;
        for (int i = 0; i < 2; i++) begin
            next_cycle();
            drive_fetch(random_word() & 16'hfffe, random_br_ir());
            next_cycle();
            drive_execute(i == 0 ? lc3b_isa_pkg::op_jmp : lc3b_isa_pkg::op_jsr, 1'b0,
                          random_word() & 16'hfffe);
            drive_fetch(random_word() & 16'hfffe, random_br_ir());
            next_cycle();
            drive_fetch(random_word() & 16'hfffe, random_br_ir());
            // a wrong outcome exposes the head's recovery address.
            next_cycle();
            drive_execute(lc3b_isa_pkg::op_br, ~pending_pred[0], '0);
        end
        finish_test("jmp and jsr", start);

        start = err_count;
        next_cycle();
        drive_fetch(random_word() & 16'hfffe, {lc3b_isa_pkg::op_add, 12'h042});
        drive_execute(lc3b_isa_pkg::op_trap, 1'b0, '0);
        next_cycle();
        drive_execute(lc3b_isa_pkg::op_jmp, 1'b0, random_word() & 16'hfffe);
        drive_writeback(lc3b_isa_pkg::op_trap, random_word() & 16'hfffe);
        finish_test("trap", start);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : branch_unit_tb
